// ==== pipe_stim.txt ====
# T test start, I addr instr, D addr data preload, E addr fetch error
# S addr data expected store in order, H cause (1 illegal, 2 fetch error)
T
I 00000200 00500093
I 00000204 ffd00113
I 00000208 002081b3
I 0000020c 40208233
I 00000210 0020f2b3
I 00000214 0020e333
I 00000218 0020c3b3
I 0000021c 00112433
I 00000220 123454b7
I 00000224 00708013
I 00000228 10302023
I 0000022c 10402223
I 00000230 10502423
I 00000234 10602623
I 00000238 10702823
I 0000023c 10802a23
I 00000240 10902c23
I 00000244 10002e23
I 00000248 00000000
S 00000100 00000002
S 00000104 00000008
S 00000108 00000005
S 0000010c fffffffd
S 00000110 fffffff8
S 00000114 00000001
S 00000118 12345000
S 0000011c 00000000
H 1
T
D 00000100 11111111
D 00000104 00000022
I 00000200 10002083
I 00000204 10402103
I 00000208 002081b3
I 0000020c 00108213
I 00000210 10302423
I 00000214 10402623
I 00000218 10802283
I 0000021c 10502823
I 00000220 00000000
S 00000108 11111133
S 0000010c 11111112
S 00000110 11111133
H 1
T
I 00000200 00100093
I 00000204 00100113
I 00000208 00208463
I 0000020c 10102023
I 00000210 00009463
I 00000214 10102223
I 00000218 00008463
I 0000021c 10202423
I 00000220 008002ef
I 00000224 10102623
I 00000228 10502823
I 0000022c 00209463
I 00000230 10102a23
I 00000234 00000000
S 00000108 00000001
S 00000110 00000224
S 00000114 00000001
H 1
T
I 00000200 00300093
I 00000204 10102023
I 00000208 00109133
I 0000020c 10102223
S 00000100 00000003
H 1
T
I 00000200 00900093
I 00000204 10102023
I 00000208 00108093
E 0000020c
I 0000020c 10102223
I 00000210 10102423
S 00000100 00000009
H 2

// ==== flist.f ====
pipe_pkg.sv
pipe_if.sv
pipe_ifu.sv
pipe_idu.sv
pipe_exu.sv
pipe_lsu.sv
pipe_mprf.sv
pipe_top.sv
tb_pipe_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench; the exit status is the test result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_pipe_top -o tb_pipe_top \
    && ./obj_dir/tb_pipe_top \
    || exit 1

// ==== tb_pipe_top.sv ====
`timescale 1ns/100ps
// Testbench of the pipeline top, programs and expected results come from pipe_stim.txt
// Memory models acknowledge and respond after 0 to 3 cycles of random delay
// Unloaded instruction addresses read as zero, which decodes as illegal
module tb_pipe_top;

import pipe_pkg::*;

logic            clk;
logic            i_rst_n;
logic            o_imem_req;
mem_cmd_e        o_imem_cmd;
logic [XLEN-1:0] o_imem_addr;
logic            i_imem_req_ack;
logic [XLEN-1:0] i_imem_rdata;
mem_resp_e       i_imem_resp;
logic            o_dmem_req;
mem_cmd_e        o_dmem_cmd;
logic [XLEN-1:0] o_dmem_addr;
logic [XLEN-1:0] o_dmem_wdata;
logic            i_dmem_req_ack;
logic [XLEN-1:0] i_dmem_rdata;
mem_resp_e       i_dmem_resp;
logic            o_halted;
exc_code_e       o_exc_code;
logic            o_ifu_busy;
logic            o_exu_busy;
logic            o_lsu_busy;

integer          seed = 32'h4abc_9476;
integer          cycle_cnt = 0;
integer          cycle_limit = 0;

logic [31:0]     imem [logic [31:0]];
logic [31:0]     dmem [logic [31:0]];
logic            err_addr [logic [31:0]];
logic [31:0]     exp_addr_q [$];
logic [31:0]     exp_data_q [$];

byte             rec_kind [0:255];
logic [31:0]     rec_a [0:255];
logic [31:0]     rec_b [0:255];
integer          rec_num = 0;

pipe_top uut (.*);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
        $display("Timeout, the core did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $fatal(1);
    end
end

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        $display("test failed");
        $fatal(1);
    end
endtask

// ------------------------------------------------------------
// Instruction memory model
// ------------------------------------------------------------
logic        im_req_q, im_ack_q, im_halt_q, im_pend;
logic [31:0] im_addr_q, im_paddr;
logic [1:0]  im_adly, im_rdly;

always @(negedge clk) begin
    if (!i_rst_n) begin
        i_imem_req_ack = 1'b0;
        i_imem_resp    = MEM_RESP_IDLE;
        i_imem_rdata   = '0;
        im_req_q       = 1'b0;
        im_ack_q       = 1'b0;
        im_halt_q      = 1'b0;
        im_pend        = 1'b0;
    end else begin
        if (im_req_q && im_ack_q) begin    // Accepted at last edge
            im_pend  = 1'b1;
            im_paddr = im_addr_q;
            im_rdly  = 2'($random(seed));
        end
        i_imem_resp = MEM_RESP_IDLE;
        if (im_pend) begin
            if (im_rdly == 0) begin
                im_pend      = 1'b0;
                i_imem_rdata = imem.exists(im_paddr) ? imem[im_paddr] : 32'h0;
                i_imem_resp  = err_addr.exists(im_paddr) ? MEM_RESP_ERR : MEM_RESP_RDY;
            end else begin
                im_rdly = im_rdly - 2'd1;
            end
        end
        if (o_imem_req && !(im_req_q && !im_ack_q)) begin
            if (im_halt_q) begin
                $display("Instruction fetch from %h issued after the halt", o_imem_addr);
                $display("test failed");
                $fatal(1);
            end
            check_value(32'(o_imem_cmd), 32'(MEM_CMD_READ), "imem command");
            im_adly = 2'($random(seed));
        end
        i_imem_req_ack = 1'b0;
        if (o_imem_req) begin
            if (im_adly == 0) i_imem_req_ack = 1'b1;
            else im_adly = im_adly - 2'd1;
        end
        im_req_q  = o_imem_req;
        im_ack_q  = i_imem_req_ack;
        im_addr_q = o_imem_addr;
        im_halt_q = o_halted;
    end
end

// ------------------------------------------------------------
// Data memory model, stores are checked when accepted
// ------------------------------------------------------------
logic        dm_req_q, dm_ack_q, dm_pend, dm_write_q;
logic [31:0] dm_addr_q, dm_wdata_q, dm_paddr, exp_a, exp_d;
logic [1:0]  dm_adly, dm_rdly;

always @(negedge clk) begin
    if (!i_rst_n) begin
        i_dmem_req_ack = 1'b0;
        i_dmem_resp    = MEM_RESP_IDLE;
        i_dmem_rdata   = '0;
        dm_req_q       = 1'b0;
        dm_ack_q       = 1'b0;
        dm_pend        = 1'b0;
    end else begin
        if (dm_req_q && dm_ack_q) begin
            if (dm_write_q) begin
                if (exp_addr_q.size() == 0) begin
                    $display("Unexpected store of %h to address %h", dm_wdata_q, dm_addr_q);
                    $display("test failed");
                    $fatal(1);
                end
                exp_a = exp_addr_q.pop_front();
                exp_d = exp_data_q.pop_front();
                check_value(dm_addr_q, exp_a, "store address");
                check_value(dm_wdata_q, exp_d, "store data");
                dmem[dm_addr_q] = dm_wdata_q;
            end
            dm_pend  = 1'b1;
            dm_paddr = dm_addr_q;
            dm_rdly  = 2'($random(seed));
        end
        i_dmem_resp = MEM_RESP_IDLE;
        if (dm_pend) begin
            if (dm_rdly == 0) begin
                dm_pend      = 1'b0;
                i_dmem_rdata = dmem.exists(dm_paddr) ? dmem[dm_paddr] : 32'h0;
                i_dmem_resp  = MEM_RESP_RDY;
            end else begin
                dm_rdly = dm_rdly - 2'd1;
            end
        end
        if (o_dmem_req && !(dm_req_q && !dm_ack_q)) dm_adly = 2'($random(seed));
        i_dmem_req_ack = 1'b0;
        if (o_dmem_req) begin
            if (dm_adly == 0) i_dmem_req_ack = 1'b1;
            else dm_adly = dm_adly - 2'd1;
        end
        dm_req_q   = o_dmem_req;
        dm_ack_q   = i_dmem_req_ack;
        dm_addr_q  = o_dmem_addr;
        dm_wdata_q = o_dmem_wdata;
        dm_write_q = (o_dmem_cmd == MEM_CMD_WRITE);
    end
end

// ------------------------------------------------------------
// Stimulus file and test sequence
// ------------------------------------------------------------
task automatic read_stim();
    integer fd;
    string  line;
    fd = $fopen("pipe_stim.txt", "r");
    if (fd == 0) begin
        $display("Cannot open the stimulus file pipe_stim.txt");
        $display("test failed");
        $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) >= "A" && line.getc(0) <= "Z") begin
            rec_kind[rec_num] = line.getc(0);
            rec_a[rec_num]    = '0;
            rec_b[rec_num]    = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h",
                          rec_a[rec_num], rec_b[rec_num]));
            rec_num = rec_num + 1;
        end
    end
    $fclose(fd);
endtask

task automatic run_test(input logic [31:0] exp_cause);
    i_rst_n = 1'b0;
    repeat (10) @(negedge clk);
    i_rst_n = 1'b1;
    check_value(32'(o_halted), 32'h0, "halted after reset");
    check_value(32'(o_exc_code), 32'(EXC_NONE), "halt cause after reset");
    check_value(32'(o_dmem_req), 32'h0, "dmem request after reset");
    check_value(32'(o_imem_req), 32'h0, "imem request during reset");
    check_value(32'(o_ifu_busy), 32'h0, "ifu busy after reset");
    check_value(32'(o_exu_busy), 32'h0, "exu busy after reset");
    check_value(32'(o_lsu_busy), 32'h0, "lsu busy after reset");
    while (!o_imem_req) @(negedge clk);
    check_value(o_imem_addr, RST_VECTOR, "first fetch address");
    while (!o_halted) @(negedge clk);
    repeat (20) @(negedge clk);     // Catch late fetches and stores
    check_value(32'(o_exc_code), exp_cause, "halt cause");
    check_value(exp_addr_q.size(), 32'h0, "stores still missing");
endtask

initial begin
    i_rst_n        = 1'b0;
    i_imem_req_ack = 1'b0;
    i_imem_rdata   = '0;
    i_imem_resp    = MEM_RESP_IDLE;
    i_dmem_req_ack = 1'b0;
    i_dmem_rdata   = '0;
    i_dmem_resp    = MEM_RESP_IDLE;
    read_stim();
    cycle_limit = 200 * rec_num;
    for (int i = 0; i < rec_num; i++) begin
        case (rec_kind[i])
            "T": begin
                imem.delete();
                dmem.delete();
                err_addr.delete();
                exp_addr_q.delete();
                exp_data_q.delete();
            end
            "I": imem[rec_a[i]] = rec_b[i];
            "D": dmem[rec_a[i]] = rec_b[i];
            "E": err_addr[rec_a[i]] = 1'b1;
            "S": begin
                exp_addr_q.push_back(rec_a[i]);
                exp_data_q.push_back(rec_b[i]);
            end
            "H": run_test(rec_a[i]);
            default: ;
        endcase
    end
    $display("test passed");
    $finish;
end

endmodule : tb_pipe_top

// ==== pipe_top.sv ====
`timescale 1ns/100ps
// Pipeline top of the RV32I subset core
// Each memory port allows one request in flight; the core halts on error
module pipe_top (
    input  logic                      clk,
    input  logic                      i_rst_n,

    // Instruction memory
    output logic                      o_imem_req,
    output pipe_pkg::mem_cmd_e        o_imem_cmd,
    output logic [pipe_pkg::XLEN-1:0] o_imem_addr,
    input  logic                      i_imem_req_ack,
    input  logic [pipe_pkg::XLEN-1:0] i_imem_rdata,
    input  pipe_pkg::mem_resp_e       i_imem_resp,

    // Data memory
    output logic                      o_dmem_req,
    output pipe_pkg::mem_cmd_e        o_dmem_cmd,
    output logic [pipe_pkg::XLEN-1:0] o_dmem_addr,
    output logic [pipe_pkg::XLEN-1:0] o_dmem_wdata,
    input  logic                      i_dmem_req_ack,
    input  logic [pipe_pkg::XLEN-1:0] i_dmem_rdata,
    input  pipe_pkg::mem_resp_e       i_dmem_resp,

    // Status
    output logic                      o_halted,
    output pipe_pkg::exc_code_e       o_exc_code,
    output logic                      o_ifu_busy,
    output logic                      o_exu_busy,
    output logic                      o_lsu_busy
);

import pipe_pkg::*;

logic            new_pc_req;
logic [XLEN-1:0] new_pc;
logic            stop_fetch;
logic            idu2exu_req;
exu_cmd_s        idu2exu_cmd;
logic            exu2idu_rdy;

ifu2idu_if  ifu2idu ();
exu2mprf_if exu2mprf ();
exu2lsu_if  exu2lsu ();

// ------------------------------------------------------------
// Pipeline units
// ------------------------------------------------------------
pipe_ifu i_pipe_ifu (
    .clk            (clk           ),
    .i_rst_n        (i_rst_n       ),
    .o_imem_req     (o_imem_req    ),
    .o_imem_cmd     (o_imem_cmd    ),
    .o_imem_addr    (o_imem_addr   ),
    .i_imem_req_ack (i_imem_req_ack),
    .i_imem_rdata   (i_imem_rdata  ),
    .i_imem_resp    (i_imem_resp   ),
    .i_new_pc_req   (new_pc_req    ),
    .i_new_pc       (new_pc        ),
    .i_stop_fetch   (stop_fetch    ),
    .ifu2idu        (ifu2idu       ),
    .o_ifu_busy     (o_ifu_busy    )
);

pipe_idu i_pipe_idu (
    .ifu2idu   (ifu2idu    ),
    .o_exu_req (idu2exu_req),
    .o_exu_cmd (idu2exu_cmd),
    .i_exu_rdy (exu2idu_rdy)
);

pipe_exu i_pipe_exu (
    .clk          (clk        ),
    .i_rst_n      (i_rst_n    ),
    .i_idu_req    (idu2exu_req),
    .i_idu_cmd    (idu2exu_cmd),
    .o_idu_rdy    (exu2idu_rdy),
    .exu2mprf     (exu2mprf   ),
    .exu2lsu      (exu2lsu    ),
    .o_new_pc_req (new_pc_req ),
    .o_new_pc     (new_pc     ),
    .o_stop_fetch (stop_fetch ),
    .o_halted     (o_halted   ),
    .o_exc_code   (o_exc_code ),
    .o_exu_busy   (o_exu_busy )
);

pipe_lsu i_pipe_lsu (
    .clk            (clk           ),
    .i_rst_n        (i_rst_n       ),
    .exu2lsu        (exu2lsu       ),
    .o_dmem_req     (o_dmem_req    ),
    .o_dmem_cmd     (o_dmem_cmd    ),
    .o_dmem_addr    (o_dmem_addr   ),
    .o_dmem_wdata   (o_dmem_wdata  ),
    .i_dmem_req_ack (i_dmem_req_ack),
    .i_dmem_rdata   (i_dmem_rdata  ),
    .i_dmem_resp    (i_dmem_resp   ),
    .o_lsu_busy     (o_lsu_busy    )
);

pipe_mprf i_pipe_mprf (
    .clk      (clk     ),
    .exu2mprf (exu2mprf)
);

endmodule : pipe_top

// ==== pipe_mprf.sv ====
`timescale 1ns/100ps
// Integer register file, x1..x31 in flops, x0 hardwired to zero
module pipe_mprf (
    input  logic      clk,
    exu2mprf_if.slave exu2mprf
);

import pipe_pkg::*;

logic [XLEN-1:0] mprf_int [1:(2**MPRF_AWIDTH)-1];

// Combinational reads
assign exu2mprf.rs1_data = (exu2mprf.rs1_addr == '0) ? '0 : mprf_int[exu2mprf.rs1_addr];
assign exu2mprf.rs2_data = (exu2mprf.rs2_addr == '0) ? '0 : mprf_int[exu2mprf.rs2_addr];

always_ff @(posedge clk) begin
    if (exu2mprf.w_req && exu2mprf.rd_addr != '0) begin
        mprf_int[exu2mprf.rd_addr] <= exu2mprf.rd_data;
    end
end

endmodule : pipe_mprf

// ==== pipe_lsu.sv ====
`timescale 1ns/100ps
// Load/store unit, one EXU access becomes one word transaction on dmem
// The EXU holds its request fields until done
module pipe_lsu (
    input  logic                      clk,
    input  logic                      i_rst_n,
    exu2lsu_if.slave                  exu2lsu,
    output logic                      o_dmem_req,
    output pipe_pkg::mem_cmd_e        o_dmem_cmd,
    output logic [pipe_pkg::XLEN-1:0] o_dmem_addr,
    output logic [pipe_pkg::XLEN-1:0] o_dmem_wdata,
    input  logic                      i_dmem_req_ack,
    input  logic [pipe_pkg::XLEN-1:0] i_dmem_rdata,
    input  pipe_pkg::mem_resp_e       i_dmem_resp,
    output logic                      o_lsu_busy
);

import pipe_pkg::*;

typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
} lsu_state_e;

lsu_state_e      state;
logic            resp_vld;
mem_cmd_e        cmd_r;
logic [XLEN-1:0] addr_r;
logic [XLEN-1:0] wdata_r;

assign resp_vld = (state == LSU_WAIT) & (i_dmem_resp != MEM_RESP_IDLE);

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        state <= LSU_IDLE;
    end else begin
        case (state)
            LSU_IDLE: if (exu2lsu.req)    state <= LSU_REQ;
            LSU_REQ:  if (i_dmem_req_ack) state <= LSU_WAIT;
            LSU_WAIT: if (resp_vld)       state <= LSU_IDLE;
            default:                      state <= LSU_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == LSU_IDLE && exu2lsu.req) begin
        cmd_r   <= exu2lsu.cmd;
        addr_r  <= exu2lsu.addr;
        wdata_r <= exu2lsu.wdata;
    end
end

assign o_dmem_req    = (state == LSU_REQ);
assign o_dmem_cmd    = cmd_r;
assign o_dmem_addr   = addr_r;
assign o_dmem_wdata  = wdata_r;
assign exu2lsu.done  = resp_vld;
assign exu2lsu.rdata = i_dmem_rdata;
assign exu2lsu.err   = resp_vld & (i_dmem_resp == MEM_RESP_ERR);
assign o_lsu_busy    = (state != LSU_IDLE);

a_no_stray_resp : assert property (@(posedge clk) disable iff (!i_rst_n)
    i_dmem_resp != MEM_RESP_IDLE |-> state == LSU_WAIT);

endmodule : pipe_lsu

// ==== pipe_exu.sv ====
`timescale 1ns/100ps
// Execution unit; ALU, LUI, branches and jumps retire in the accept cycle
// Loads and stores keep the command waiting in the IFU buffer until LSU done
// Halt is sticky until reset
module pipe_exu (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_idu_req,
    input  pipe_pkg::exu_cmd_s        i_idu_cmd,
    output logic                      o_idu_rdy,
    exu2mprf_if.master                exu2mprf,
    exu2lsu_if.master                 exu2lsu,
    output logic                      o_new_pc_req,
    output logic [pipe_pkg::XLEN-1:0] o_new_pc,
    output logic                      o_stop_fetch,
    output logic                      o_halted,
    output pipe_pkg::exc_code_e       o_exc_code,
    output logic                      o_exu_busy
);

import pipe_pkg::*;

logic [XLEN-1:0] pc;
logic            halted;
exc_code_e       exc_code;

logic            bad;           // Illegal or failed fetch
logic            mem_op;
logic            accept;
logic            taken;
logic [XLEN-1:0] op_a;
logic [XLEN-1:0] op_b;
logic [XLEN-1:0] alu_res;
logic [XLEN-1:0] pc_inc;
logic [XLEN-1:0] target;

assign bad       = i_idu_cmd.illegal | i_idu_cmd.fetch_err;
assign mem_op    = i_idu_req & ~bad & (i_idu_cmd.load | i_idu_cmd.store);
assign o_idu_rdy = ~halted & (~mem_op | exu2lsu.done);
assign accept    = i_idu_req & o_idu_rdy;

// ------------------------------------------------------------
// ALU
// ------------------------------------------------------------
assign exu2mprf.rs1_addr = i_idu_cmd.rs1_addr;
assign exu2mprf.rs2_addr = i_idu_cmd.rs2_addr;
assign op_a = exu2mprf.rs1_data;
assign op_b = i_idu_cmd.imm_sel ? i_idu_cmd.imm : exu2mprf.rs2_data;

always_comb begin
    case (i_idu_cmd.alu_op)
        ALU_SUB:    alu_res = op_a - op_b;
        ALU_AND:    alu_res = op_a & op_b;
        ALU_OR:     alu_res = op_a | op_b;
        ALU_XOR:    alu_res = op_a ^ op_b;
        ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
        ALU_PASS_B: alu_res = op_b;     // LUI
        default:    alu_res = op_a + op_b;
    endcase
end

// ------------------------------------------------------------
// Branches, jumps and writeback
// ------------------------------------------------------------
assign taken  = i_idu_cmd.jump |
                (i_idu_cmd.branch & ((exu2mprf.rs1_data == exu2mprf.rs2_data) ^ i_idu_cmd.bne));
assign pc_inc = pc + XLEN'(4);
assign target = pc + i_idu_cmd.imm;

assign o_new_pc_req = accept & ~bad & taken;
assign o_new_pc     = target;

assign exu2mprf.w_req   = accept & ~bad & i_idu_cmd.rd_wr & ~exu2lsu.err;
assign exu2mprf.rd_addr = i_idu_cmd.rd_addr;
assign exu2mprf.rd_data = i_idu_cmd.jump ? pc_inc :         // Link address
                          i_idu_cmd.load ? exu2lsu.rdata : alu_res;

assign exu2lsu.req   = mem_op & ~halted;
assign exu2lsu.cmd   = i_idu_cmd.store ? MEM_CMD_WRITE : MEM_CMD_READ;
assign exu2lsu.addr  = alu_res;
assign exu2lsu.wdata = exu2mprf.rs2_data;

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        pc       <= RST_VECTOR;
        halted   <= 1'b0;
        exc_code <= EXC_NONE;
    end else if (accept) begin
        if (i_idu_cmd.fetch_err) begin
            halted   <= 1'b1;
            exc_code <= EXC_FETCH_ERR;
        end else if (i_idu_cmd.illegal) begin
            halted   <= 1'b1;
            exc_code <= EXC_ILLEGAL_INSTR;
        end else if (exu2lsu.err) begin
            halted   <= 1'b1;
            exc_code <= EXC_DATA_ERR;
        end else begin
            pc <= taken ? target : pc_inc;
        end
    end
end

assign o_stop_fetch = halted;
assign o_halted     = halted;
assign o_exc_code   = exc_code;
assign o_exu_busy   = exu2lsu.req;

a_no_redirect_halted : assert property (@(posedge clk) disable iff (!i_rst_n)
    halted |-> !o_new_pc_req && !exu2lsu.req);

endmodule : pipe_exu

// ==== pipe_idu.sv ====
`timescale 1ns/100ps
// Combinational decoder for the supported RV32I subset
// Anything outside LUI, ADDI, ADD/SUB/AND/OR/XOR/SLT, BEQ/BNE, JAL, LW, SW is illegal
module pipe_idu (
    ifu2idu_if.sink            ifu2idu,
    output logic               o_exu_req,
    output pipe_pkg::exu_cmd_s o_exu_cmd,
    input  logic               i_exu_rdy
);

import pipe_pkg::*;

logic [XLEN-1:0] instr;
logic [6:0]      opcode;
logic [2:0]      funct3;
logic [6:0]      funct7;
logic [XLEN-1:0] imm_i;
logic [XLEN-1:0] imm_s;
logic [XLEN-1:0] imm_b;
logic [XLEN-1:0] imm_j;
logic [XLEN-1:0] imm_u;
exu_cmd_s        cmd;

assign instr  = ifu2idu.instr;
assign opcode = instr[6:0];
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];

// ------------------------------------------------------------
// Immediates
// ------------------------------------------------------------
assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
assign imm_u = {instr[31:12], 12'h000};

always_comb begin
    cmd           = '0;
    cmd.rs1_addr  = instr[19:15];
    cmd.rs2_addr  = instr[24:20];
    cmd.rd_addr   = instr[11:7];
    cmd.alu_op    = ALU_ADD;
    cmd.fetch_err = ifu2idu.imem_err;
    case (opcode)
        OPC_LUI: begin
            cmd.imm     = imm_u;
            cmd.imm_sel = 1'b1;
            cmd.alu_op  = ALU_PASS_B;
            cmd.rd_wr   = 1'b1;
        end
        OPC_OP_IMM: begin
            cmd.imm     = imm_i;
            cmd.imm_sel = 1'b1;
            cmd.rd_wr   = 1'b1;
            cmd.illegal = (funct3 != 3'b000);       // ADDI only
        end
        OPC_OP: begin
            cmd.rd_wr = 1'b1;
            case ({funct7, funct3})
                {7'h00, 3'b000}: cmd.alu_op = ALU_ADD;
                {7'h20, 3'b000}: cmd.alu_op = ALU_SUB;
                {7'h00, 3'b111}: cmd.alu_op = ALU_AND;
                {7'h00, 3'b110}: cmd.alu_op = ALU_OR;
                {7'h00, 3'b100}: cmd.alu_op = ALU_XOR;
                {7'h00, 3'b010}: cmd.alu_op = ALU_SLT;
                default:         cmd.illegal = 1'b1;
            endcase
        end
        OPC_BRANCH: begin
            cmd.imm     = imm_b;
            cmd.branch  = 1'b1;
            cmd.bne     = funct3[0];
            cmd.illegal = (funct3[2:1] != 2'b00);   // BEQ and BNE only
        end
        OPC_JAL: begin
            cmd.imm   = imm_j;
            cmd.jump  = 1'b1;
            cmd.rd_wr = 1'b1;
        end
        OPC_LOAD: begin
            cmd.imm     = imm_i;
            cmd.imm_sel = 1'b1;
            cmd.rd_wr   = 1'b1;
            cmd.load    = 1'b1;
            cmd.illegal = (funct3 != 3'b010);       // Word access only
        end
        OPC_STORE: begin
            cmd.imm     = imm_s;
            cmd.imm_sel = 1'b1;
            cmd.store   = 1'b1;
            cmd.illegal = (funct3 != 3'b010);
        end
        default: cmd.illegal = 1'b1;
    endcase
end

assign o_exu_req   = ifu2idu.vd;
assign o_exu_cmd   = cmd;
assign ifu2idu.rdy = i_exu_rdy;

endmodule : pipe_idu

// ==== pipe_ifu.sv ====
`timescale 1ns/100ps
// Fetch unit, one imem request in flight and a one-entry instruction buffer
// A new PC flushes the buffer; a response still in flight is dropped
module pipe_ifu (
    input  logic                      clk,
    input  logic                      i_rst_n,
    output logic                      o_imem_req,
    output pipe_pkg::mem_cmd_e        o_imem_cmd,
    output logic [pipe_pkg::XLEN-1:0] o_imem_addr,
    input  logic                      i_imem_req_ack,
    input  logic [pipe_pkg::XLEN-1:0] i_imem_rdata,
    input  pipe_pkg::mem_resp_e       i_imem_resp,
    input  logic                      i_new_pc_req,
    input  logic [pipe_pkg::XLEN-1:0] i_new_pc,
    input  logic                      i_stop_fetch,
    ifu2idu_if.source                 ifu2idu,
    output logic                      o_ifu_busy
);

import pipe_pkg::*;

logic            imem_req_r;        // Waiting for acknowledge
logic            wait_resp;         // Accepted, response pending
logic            discard;           // Pending response is stale
logic [XLEN-1:0] fetch_pc;          // Next address to request
logic [XLEN-1:0] req_addr;
logic            buf_vd;
logic [XLEN-1:0] buf_instr;
logic            buf_err;

logic            req_acked;
logic            resp_vld;
logic            buf_fill;
logic            buf_empty_nxt;
logic            issue;
logic [XLEN-1:0] pc_sel;

assign req_acked     = imem_req_r & i_imem_req_ack;
assign resp_vld      = wait_resp & (i_imem_resp != MEM_RESP_IDLE);
assign buf_fill      = resp_vld & ~discard;
assign buf_empty_nxt = i_new_pc_req | (~buf_fill & (~buf_vd | ifu2idu.rdy));
assign issue         = ~imem_req_r & (~wait_resp | resp_vld) & buf_empty_nxt & ~i_stop_fetch;
assign pc_sel        = i_new_pc_req ? i_new_pc : fetch_pc;

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        imem_req_r <= 1'b0;
        wait_resp  <= 1'b0;
        discard    <= 1'b0;
        buf_vd     <= 1'b0;
        fetch_pc   <= RST_VECTOR;
    end else begin
        if (issue) begin
            imem_req_r <= 1'b1;
        end else if (req_acked) begin
            imem_req_r <= 1'b0;
        end
        if (req_acked) begin
            wait_resp <= 1'b1;
        end else if (resp_vld) begin
            wait_resp <= 1'b0;
        end
        if (i_new_pc_req) begin
            discard <= imem_req_r | (wait_resp & ~resp_vld);   // Anything still in flight
        end else if (resp_vld) begin
            discard <= 1'b0;
        end
        if (i_new_pc_req) begin
            buf_vd <= 1'b0;
        end else if (buf_fill) begin
            buf_vd <= 1'b1;
        end else if (ifu2idu.rdy) begin
            buf_vd <= 1'b0;
        end
        if (issue) begin
            fetch_pc <= pc_sel + XLEN'(4);
        end else if (i_new_pc_req) begin
            fetch_pc <= i_new_pc;
        end
    end
end

always_ff @(posedge clk) begin
    if (issue) begin
        req_addr <= pc_sel;
    end
    if (buf_fill) begin
        buf_instr <= i_imem_rdata;
        buf_err   <= (i_imem_resp == MEM_RESP_ERR);    // ERR travels as a marked word
    end
end

assign o_imem_req       = imem_req_r;
assign o_imem_cmd       = MEM_CMD_READ;
assign o_imem_addr      = req_addr;
assign ifu2idu.vd       = buf_vd;
assign ifu2idu.instr    = buf_instr;
assign ifu2idu.imem_err = buf_err;
assign o_ifu_busy       = imem_req_r | wait_resp | buf_vd;

a_imem_addr_stable : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_imem_req && !i_imem_req_ack |=> $stable(o_imem_addr));

endmodule : pipe_ifu

// ==== pipe_if.sv ====
`timescale 1ns/100ps
// Internal pipeline interfaces
// Register file reads are combinational, writes land at the clock edge

// IFU to IDU instruction stream, word passes when vd and rdy are high
interface ifu2idu_if;
    import pipe_pkg::*;

    logic            vd;
    logic [XLEN-1:0] instr;
    logic            imem_err;
    logic            rdy;

    modport source (output vd, instr, imem_err, input rdy);
    modport sink   (input vd, instr, imem_err, output rdy);
endinterface : ifu2idu_if

interface exu2mprf_if;
    import pipe_pkg::*;

    logic [MPRF_AWIDTH-1:0] rs1_addr;
    logic [XLEN-1:0]        rs1_data;
    logic [MPRF_AWIDTH-1:0] rs2_addr;
    logic [XLEN-1:0]        rs2_data;
    logic                   w_req;
    logic [MPRF_AWIDTH-1:0] rd_addr;
    logic [XLEN-1:0]        rd_data;

    modport master (output rs1_addr, rs2_addr, w_req, rd_addr, rd_data,
                    input  rs1_data, rs2_data);
    modport slave  (input  rs1_addr, rs2_addr, w_req, rd_addr, rd_data,
                    output rs1_data, rs2_data);
endinterface : exu2mprf_if

// req is held until done, rdata and err are valid with done
interface exu2lsu_if;
    import pipe_pkg::*;

    logic            req;
    mem_cmd_e        cmd;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            done;
    logic [XLEN-1:0] rdata;
    logic            err;

    modport master (output req, cmd, addr, wdata, input done, rdata, err);
    modport slave  (input req, cmd, addr, wdata, output done, rdata, err);
endinterface : exu2lsu_if

// ==== pipe_pkg.sv ====
// Shared definitions of the RV32I subset core
// Data accesses are full words only, so no access width is carried
// Reset vector must be word aligned
package pipe_pkg;

localparam int XLEN        = 32;
localparam int MPRF_AWIDTH = 5;

localparam logic [XLEN-1:0] RST_VECTOR = 32'h0000_0200;

// ------------------------------------------------------------
// Major opcodes of the supported instructions
// ------------------------------------------------------------
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;

typedef enum logic {
    MEM_CMD_READ  = 1'b0,
    MEM_CMD_WRITE = 1'b1
} mem_cmd_e;

typedef enum logic [1:0] {
    MEM_RESP_IDLE = 2'b00,
    MEM_RESP_RDY  = 2'b01,
    MEM_RESP_ERR  = 2'b10
} mem_resp_e;

typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
} alu_op_e;

typedef enum logic [1:0] {
    EXC_NONE          = 2'd0,
    EXC_ILLEGAL_INSTR = 2'd1,
    EXC_FETCH_ERR     = 2'd2,
    EXC_DATA_ERR      = 2'd3
} exc_code_e;

// ------------------------------------------------------------
// Decoded command from IDU to EXU
// ------------------------------------------------------------
typedef struct packed {
    logic [MPRF_AWIDTH-1:0] rs1_addr;
    logic [MPRF_AWIDTH-1:0] rs2_addr;
    logic [MPRF_AWIDTH-1:0] rd_addr;
    logic [XLEN-1:0]        imm;
    alu_op_e                alu_op;
    logic                   imm_sel;    // Immediate as operand B
    logic                   rd_wr;
    logic                   load;
    logic                   store;
    logic                   branch;
    logic                   bne;        // Branch on not equal
    logic                   jump;
    logic                   illegal;
    logic                   fetch_err;
} exu_cmd_s;

endpackage : pipe_pkg
